// File: Bender.yml
package:
  name: icache

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/icache_pkg.sv
      - hdl/icache_fill_if.sv
      - hdl/icache_bram.sv
      - hdl/icache_lookup.sv
      - hdl/icache_miss_unit.sv
      - hdl/icache.sv
  - target: test
    files:
      - testbench/tb_icache.sv

// File: hdl/icache.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module icache (
    input  logic                                          CLK,
    input  logic                                          nRST,

    // lookup from the fetch unit
    input  logic                                          core_req_valid,
    input  logic [`ICACHE_INDEX_W-1:0]                    core_req_index,
    input  logic [`ICACHE_BLKOFF_W-1:0]                   core_req_blkoff,

    // per-way response, one cycle later
    output logic [`ICACHE_ASSOC-1:0]                      core_resp_valid_by_way,
    output logic [`ICACHE_ASSOC-1:0][`ICACHE_TAG_W-1:0]   core_resp_tag_by_way,
    output logic [`ICACHE_ASSOC-1:0][`ICACHE_FETCH_W-1:0] core_resp_instr_by_way,

    // hit or miss feedback in the response cycle
    input  logic                                          core_resp_hit_valid,
    input  logic [`ICACHE_WAY_W-1:0]                      core_resp_hit_way,
    input  logic                                          core_resp_miss_valid,
    input  logic [`ICACHE_TAG_W-1:0]                      core_resp_miss_tag,

    // L2 request, ready/valid
    output logic                                          l2_req_valid,
    output logic [`ICACHE_BLOCK_ADDR_W-1:0]               l2_req_addr,
    input  logic                                          l2_req_ready,

    // L2 response, single pulse
    input  logic                                          l2_resp_valid,
    input  logic [`ICACHE_BLOCK_ADDR_W-1:0]               l2_resp_addr,
    input  logic [`ICACHE_BLOCK_W-1:0]                    l2_resp_data
);

    icache_fill_if fill ();

    icache_lookup i_lookup (
        .CLK                   (CLK),
        .nRST                  (nRST),
        .core_req_valid        (core_req_valid),
        .core_req_index        (core_req_index),
        .core_req_blkoff       (core_req_blkoff),
        .core_resp_hit_valid   (core_resp_hit_valid),
        .core_resp_hit_way     (core_resp_hit_way),
        .core_resp_valid_by_way(core_resp_valid_by_way),
        .core_resp_tag_by_way  (core_resp_tag_by_way),
        .core_resp_instr_by_way(core_resp_instr_by_way),
        .fill                  (fill.lookup)
    );

    icache_miss_unit i_miss (
        .CLK                 (CLK),
        .nRST                (nRST),
        .core_resp_miss_valid(core_resp_miss_valid),
        .core_resp_miss_tag  (core_resp_miss_tag),
        .l2_req_valid        (l2_req_valid),
        .l2_req_addr         (l2_req_addr),
        .l2_req_ready        (l2_req_ready),
        .l2_resp_valid       (l2_resp_valid),
        .l2_resp_addr        (l2_resp_addr),
        .l2_resp_data        (l2_resp_data),
        .fill                (fill.miss)
    );

endmodule

`default_nettype wire

// File: hdl/icache_bram.sv
`timescale 1ns/100ps
`default_nettype none

module icache_bram #(
    parameter int WIDTH_BYTES = 6,
    parameter int DEPTH       = 128
) (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       ren,
    input  logic [$clog2(DEPTH)-1:0]   rindex,
    output logic [WIDTH_BYTES*8-1:0]   rdata,
    input  logic [WIDTH_BYTES-1:0]     wen_byte,
    input  logic [$clog2(DEPTH)-1:0]   windex,
    input  logic [WIDTH_BYTES*8-1:0]   wdata
);

    logic [DEPTH-1:0][WIDTH_BYTES-1:0][7:0] mem;

    // byte-enabled write, whole array cleared on reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            mem <= '0;
        end else begin
            for (int b = 0; b < WIDTH_BYTES; b++) begin
                if (wen_byte[b]) begin
                    mem[windex][b] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            rdata <= '0;
        end else if (ren) begin
            rdata <= mem[rindex];
        end
    end

endmodule

`default_nettype wire

// File: hdl/icache_fill_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

interface icache_fill_if
    import icache_pkg::*;
();

    // response stage, owned by the lookup side
    logic                       resp_valid;
    logic [`ICACHE_INDEX_W-1:0] resp_index;
    logic [`ICACHE_WAY_W-1:0]   victim_way;

    // fill writes, owned by the miss register
    logic [`ICACHE_ASSOC-1:0]    tag_wen;
    logic [`ICACHE_ASSOC-1:0]    data_wen;
    icache_block_addr_u          fill_addr;
    logic [`ICACHE_BLKOFF_W-1:0] fill_blkoff;
    logic                        fill_tag_valid;
    logic [`ICACHE_FETCH_W-1:0]  fill_data;

    modport lookup (
        output resp_valid, resp_index, victim_way,
        input  tag_wen, data_wen, fill_addr, fill_blkoff, fill_tag_valid, fill_data
    );

    modport miss (
        input  resp_valid, resp_index, victim_way,
        output tag_wen, data_wen, fill_addr, fill_blkoff, fill_tag_valid, fill_data
    );

endinterface

`default_nettype wire

// File: hdl/icache_lookup.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module icache_lookup (
    input  logic                                          CLK,
    input  logic                                          nRST,
    input  logic                                          core_req_valid,
    input  logic [`ICACHE_INDEX_W-1:0]                    core_req_index,
    input  logic [`ICACHE_BLKOFF_W-1:0]                   core_req_blkoff,
    input  logic                                          core_resp_hit_valid,
    input  logic [`ICACHE_WAY_W-1:0]                      core_resp_hit_way,
    output logic [`ICACHE_ASSOC-1:0]                      core_resp_valid_by_way,
    output logic [`ICACHE_ASSOC-1:0][`ICACHE_TAG_W-1:0]   core_resp_tag_by_way,
    output logic [`ICACHE_ASSOC-1:0][`ICACHE_FETCH_W-1:0] core_resp_instr_by_way,
    icache_fill_if.lookup                                 fill
);

    localparam int TAG_ENTRY_W    = `ICACHE_TAG_ENTRY_BYTES * 8;
    localparam int TAG_PAD_W      = TAG_ENTRY_W - `ICACHE_TAG_W - 1;
    localparam int TAG_RAM_BYTES  = `ICACHE_ASSOC * `ICACHE_TAG_ENTRY_BYTES;
    localparam int DATA_RAM_BYTES = `ICACHE_ASSOC * `ICACHE_FETCH_BYTES;
    localparam int DATA_RAM_DEPTH = `ICACHE_NUM_SETS * (2 ** `ICACHE_BLKOFF_W);

    logic [TAG_RAM_BYTES*8-1:0]  tag_rdata;
    logic [TAG_RAM_BYTES-1:0]    tag_wen_byte;
    logic [TAG_RAM_BYTES*8-1:0]  tag_wdata;
    logic [DATA_RAM_BYTES*8-1:0] data_rdata;
    logic [DATA_RAM_BYTES-1:0]   data_wen_byte;
    logic [DATA_RAM_BYTES*8-1:0] data_wdata;

    logic [`ICACHE_ASSOC-1:0] way_valid;

    // one bit per set, names the next victim
    logic [`ICACHE_NUM_SETS-1:0][`ICACHE_WAY_W-1:0] plru_bits;

    // --------------------
    // response stage

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            fill.resp_valid <= 1'b0;
            fill.resp_index <= '0;
        end else begin
            fill.resp_valid <= core_req_valid;
            fill.resp_index <= core_req_index;
        end
    end

    always_comb begin
        for (int w = 0; w < `ICACHE_ASSOC; w++) begin
            way_valid[w]              = tag_rdata[w*TAG_ENTRY_W + TAG_ENTRY_W - 1];
            core_resp_tag_by_way[w]   = tag_rdata[w*TAG_ENTRY_W +: `ICACHE_TAG_W];
            core_resp_instr_by_way[w] = data_rdata[w*`ICACHE_FETCH_W +: `ICACHE_FETCH_W];
        end
    end

    assign core_resp_valid_by_way = way_valid;

    // lowest invalid way wins, else the plru choice
    always_comb begin
        fill.victim_way = plru_bits[fill.resp_index];
        for (int w = `ICACHE_ASSOC - 1; w >= 0; w--) begin
            if (!way_valid[w]) begin
                fill.victim_way = `ICACHE_WAY_W'(w);
            end
        end
    end

    // point away from the way that just hit
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            plru_bits <= '0;
        end else if (fill.resp_valid & core_resp_hit_valid) begin
            plru_bits[fill.resp_index] <= ~core_resp_hit_way;
        end
    end

    // --------------------
    // fill write words

    // same word for every way, byte enables pick the victim
    always_comb begin
        for (int w = 0; w < `ICACHE_ASSOC; w++) begin
            tag_wen_byte[w*`ICACHE_TAG_ENTRY_BYTES +: `ICACHE_TAG_ENTRY_BYTES] =
                {`ICACHE_TAG_ENTRY_BYTES{fill.tag_wen[w]}};
            data_wen_byte[w*`ICACHE_FETCH_BYTES +: `ICACHE_FETCH_BYTES] =
                {`ICACHE_FETCH_BYTES{fill.data_wen[w]}};
            tag_wdata[w*TAG_ENTRY_W +: TAG_ENTRY_W] =
                {fill.fill_tag_valid, {TAG_PAD_W{1'b0}}, fill.fill_addr.fields.tag};
            data_wdata[w*`ICACHE_FETCH_W +: `ICACHE_FETCH_W] = fill.fill_data;
        end
    end

    icache_bram #(
        .WIDTH_BYTES(TAG_RAM_BYTES),
        .DEPTH      (`ICACHE_NUM_SETS)
    ) tag_ram (
        .CLK     (CLK),
        .nRST    (nRST),
        .ren     (core_req_valid),
        .rindex  (core_req_index),
        .rdata   (tag_rdata),
        .wen_byte(tag_wen_byte),
        .windex  (fill.fill_addr.fields.index),
        .wdata   (tag_wdata)
    );

    icache_bram #(
        .WIDTH_BYTES(DATA_RAM_BYTES),
        .DEPTH      (DATA_RAM_DEPTH)
    ) data_ram (
        .CLK     (CLK),
        .nRST    (nRST),
        .ren     (core_req_valid),
        .rindex  ({core_req_index, core_req_blkoff}),
        .rdata   (data_rdata),
        .wen_byte(data_wen_byte),
        .windex  ({fill.fill_addr.fields.index, fill.fill_blkoff}),
        .wdata   (data_wdata)
    );

endmodule

`default_nettype wire

// File: hdl/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// --------------------
// cache geometry

`define ICACHE_ASSOC            2
`define ICACHE_WAY_W            1
`define ICACHE_NUM_SETS         128
`define ICACHE_INDEX_W          7
`define ICACHE_TAG_W            22
`define ICACHE_BLOCK_ADDR_W     (`ICACHE_TAG_W + `ICACHE_INDEX_W)

// --------------------
// fetch and block widths

`define ICACHE_FETCH_BYTES      16
`define ICACHE_FETCH_W          128
`define ICACHE_BLOCK_W          256
// selects the 16B half of a 32B block
`define ICACHE_BLKOFF_W         1

// valid, one pad bit, then the tag
`define ICACHE_TAG_ENTRY_BYTES  3

`endif

// File: hdl/icache_miss_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module icache_miss_unit
    import icache_pkg::*;
(
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic                            core_resp_miss_valid,
    input  logic [`ICACHE_TAG_W-1:0]        core_resp_miss_tag,
    output logic                            l2_req_valid,
    output logic [`ICACHE_BLOCK_ADDR_W-1:0] l2_req_addr,
    input  logic                            l2_req_ready,
    input  logic                            l2_resp_valid,
    input  logic [`ICACHE_BLOCK_ADDR_W-1:0] l2_resp_addr,
    input  logic [`ICACHE_BLOCK_W-1:0]      l2_resp_data,
    icache_fill_if.miss                     fill
);

    // --------------------
    // miss register

    logic                        miss_valid, next_miss_valid;
    logic                        miss_requested, next_miss_requested;
    logic                        miss_data_valid, next_miss_data_valid;
    logic [`ICACHE_BLKOFF_W-1:0] miss_blkoff, next_miss_blkoff;
    logic                        miss_delay, next_miss_delay;

    // payload, only meaningful while miss_valid
    icache_block_addr_u                                      miss_addr;
    logic [`ICACHE_WAY_W-1:0]                                miss_way;
    logic [2**`ICACHE_BLKOFF_W-1:0][`ICACHE_FETCH_W-1:0]     miss_buffer;

    icache_block_addr_u new_addr;
    logic               same_block;
    logic               alloc;
    logic               capture;

    always_comb begin
        new_addr.fields.tag   = core_resp_miss_tag;
        new_addr.fields.index = fill.resp_index;
        same_block = miss_valid & (miss_addr.raw == new_addr.raw);

        next_miss_valid      = miss_valid;
        next_miss_requested  = miss_requested;
        next_miss_data_valid = miss_data_valid;
        next_miss_blkoff     = miss_blkoff;
        next_miss_delay      = 1'b0;
        alloc                = 1'b0;
        capture              = 1'b0;

        if (miss_data_valid) begin
            // one half per cycle, then the idle cycle
            if (miss_blkoff == '1) begin
                next_miss_data_valid = 1'b0;
                next_miss_delay      = 1'b1;
            end else begin
                next_miss_blkoff = miss_blkoff + 1'b1;
            end
        end else if (miss_delay) begin
            next_miss_valid = 1'b0;
        end else if (fill.resp_valid & core_resp_miss_valid & ~same_block) begin
            // new block, replaces a miss still waiting on L2
            alloc               = 1'b1;
            next_miss_valid     = 1'b1;
            next_miss_requested = 1'b0;
            next_miss_blkoff    = '0;
        end else if (miss_valid) begin
            if (l2_resp_valid & (l2_resp_addr == miss_addr.raw)) begin
                capture              = 1'b1;
                next_miss_requested  = 1'b1;
                next_miss_data_valid = 1'b1;
                next_miss_blkoff     = '0;
            end else if (~miss_requested & l2_req_ready) begin
                next_miss_requested = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            miss_valid      <= 1'b0;
            miss_requested  <= 1'b0;
            miss_data_valid <= 1'b0;
            miss_blkoff     <= '0;
            miss_delay      <= 1'b0;
        end else begin
            miss_valid      <= next_miss_valid;
            miss_requested  <= next_miss_requested;
            miss_data_valid <= next_miss_data_valid;
            miss_blkoff     <= next_miss_blkoff;
            miss_delay      <= next_miss_delay;
        end
    end

    always_ff @(posedge CLK) begin
        if (alloc) begin
            miss_addr <= new_addr;
            miss_way  <= fill.victim_way;
        end
        if (capture) begin
            miss_buffer <= l2_resp_data;
        end
    end

    // --------------------
    // L2 request and fill strobes

    assign l2_req_valid = miss_valid & ~miss_requested;
    assign l2_req_addr  = miss_addr.raw;

    // tag written on both halves, valid only with the last
    always_comb begin
        for (int w = 0; w < `ICACHE_ASSOC; w++) begin
            fill.data_wen[w] = miss_data_valid & (miss_way == `ICACHE_WAY_W'(w));
            fill.tag_wen[w]  = miss_data_valid & (miss_way == `ICACHE_WAY_W'(w));
        end
    end

    assign fill.fill_addr      = miss_addr;
    assign fill.fill_blkoff    = miss_blkoff;
    assign fill.fill_tag_valid = (miss_blkoff == '1);
    assign fill.fill_data      = miss_buffer[miss_blkoff];

endmodule

`default_nettype wire

// File: hdl/icache_pkg.sv
`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

    // L2 block address, raw word or tag over index
    typedef union packed {
        logic [`ICACHE_BLOCK_ADDR_W-1:0] raw;
        struct packed {
            logic [`ICACHE_TAG_W-1:0]   tag;
            logic [`ICACHE_INDEX_W-1:0] index;
        } fields;
    } icache_block_addr_u;

endpackage

`default_nettype wire

// File: sim.f
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_fill_if.sv
hdl/icache_bram.sv
hdl/icache_lookup.sv
hdl/icache_miss_unit.sv
hdl/icache.sv
testbench/tb_icache.sv

// File: testbench/icache_stim.txt
# L index half valid_mask tag_way0 tag_way1 fetch_tag   (all hex)
# M index miss_tag ready_low_cycles ; F victim_way has_stray stray_addr block_data
# empty cache after reset
L 00 0 0 000000 000000 000000
L 25 1 0 000000 000000 000000
L 7f 0 0 000000 000000 000000
# first miss in set 25, back-pressure and a stray response
M 25 012345 3
F 0 1 091a2a6 00112233445566778899aabbccddeeff0f1e2d3c4b5a69788796a5b4c3d2e1f0
L 25 1 1 012345 000000 000000
L 25 0 1 012345 000000 012345
# second miss goes to the lowest invalid way
M 25 0abcde 0
F 1 0 0000000 a5a5a5a55a5a5a5adeadbeefcafef00d0123456789abcdef1122334455667788
L 25 0 3 012345 0abcde 0abcde
# hit way 0, next victim is way 1
L 25 1 3 012345 0abcde 012345
M 25 3c0ffe 2
F 1 1 0000025 1111111122222222333333334444444455555555666666667777777788888888
# hit way 1, next victim is way 0
L 25 0 3 012345 3c0ffe 3c0ffe
M 25 155aa5 1
F 0 0 0000000 f0e1d2c3b4a5968778695a4b3c2d1e0f13579bdf2468ace0fdb97531eca86420
L 25 1 3 155aa5 3c0ffe 155aa5
L 25 0 3 155aa5 3c0ffe 3c0ffe
# another set stays independent
M 00 2a5a5a 0
F 0 0 0000000 8badf00dfeedface0badc0dedeadc0de0123abcd4567ef0189abcdef76543210
L 00 1 1 2a5a5a 000000 2a5a5a
L 7f 1 0 000000 000000 000000

// File: testbench/tb_icache.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_macros.svh"

module tb_icache
    import icache_pkg::*;
();

    localparam int MAX_CMDS   = 64;
    localparam int NUM_FIELDS = 6;

    logic                                          CLK;
    logic                                          nRST;
    logic                                          core_req_valid;
    logic [`ICACHE_INDEX_W-1:0]                    core_req_index;
    logic [`ICACHE_BLKOFF_W-1:0]                   core_req_blkoff;
    logic [`ICACHE_ASSOC-1:0]                      core_resp_valid_by_way;
    logic [`ICACHE_ASSOC-1:0][`ICACHE_TAG_W-1:0]   core_resp_tag_by_way;
    logic [`ICACHE_ASSOC-1:0][`ICACHE_FETCH_W-1:0] core_resp_instr_by_way;
    logic                                          core_resp_hit_valid;
    logic [`ICACHE_WAY_W-1:0]                      core_resp_hit_way;
    logic                                          core_resp_miss_valid;
    logic [`ICACHE_TAG_W-1:0]                      core_resp_miss_tag;
    logic                                          l2_req_valid;
    logic [`ICACHE_BLOCK_ADDR_W-1:0]               l2_req_addr;
    logic                                          l2_req_ready;
    logic                                          l2_resp_valid;
    logic [`ICACHE_BLOCK_ADDR_W-1:0]               l2_resp_addr;
    logic [`ICACHE_BLOCK_W-1:0]                    l2_resp_data;

    // parsed stimulus lines
    logic [7:0]                 cmds   [0:MAX_CMDS-1];
    logic [`ICACHE_BLOCK_W-1:0] fields [0:MAX_CMDS-1][0:NUM_FIELDS-1];
    int                         cmd_count = 0;
    logic                       stim_loaded = 1'b0;

    // blocks already returned by the L2 model
    logic [`ICACHE_BLOCK_ADDR_W-1:0] blk_addr [0:MAX_CMDS-1];
    logic [`ICACHE_BLOCK_W-1:0]      blk_data [0:MAX_CMDS-1];
    int                              blk_count = 0;

    icache_block_addr_u pending_addr;
    logic               miss_pending = 1'b0;
    int                 error_count = 0;

    icache i_icache (.*);

    always begin
        CLK = 1'b0;
        #50;
        CLK = 1'b1;
        #50;
    end

    // --------------------
    // failure reporting

    task automatic fail_value(input string msg);
        error_count++;
        $display("FAIL @%0t: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    initial begin : watchdog
        wait (stim_loaded);
        repeat (200 * cmd_count) @(posedge CLK);
        $display("timeout: the stimulus did not finish within %0d cycles", 200 * cmd_count);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    // --------------------
    // compare tasks

    task automatic check_resp(
        input logic [`ICACHE_ASSOC-1:0]                    valid_act,
        input logic [`ICACHE_ASSOC-1:0][`ICACHE_TAG_W-1:0] tag_act,
        input logic [`ICACHE_ASSOC-1:0]                    valid_exp,
        input logic [`ICACHE_ASSOC-1:0][`ICACHE_TAG_W-1:0] tag_exp,
        input logic [`ICACHE_ASSOC-1:0]                    care,
        input string                                       what
    );
        for (int w = 0; w < `ICACHE_ASSOC; w++) begin
            if (care[w] && valid_act[w] !== valid_exp[w]) begin
                fail_value($sformatf("%s way %0d valid %b, expected %b",
                                     what, w, valid_act[w], valid_exp[w]));
            end
            if (care[w] && valid_exp[w] && tag_act[w] !== tag_exp[w]) begin
                fail_value($sformatf("%s way %0d tag %h, expected %h",
                                     what, w, tag_act[w], tag_exp[w]));
            end
        end
    endtask

    task automatic check_instr(
        input logic [`ICACHE_FETCH_W-1:0] act,
        input logic [`ICACHE_FETCH_W-1:0] exp,
        input string                      what
    );
        if (act !== exp) begin
            fail_value($sformatf("%s chunk %h, expected %h", what, act, exp));
        end
    endtask

    task automatic check_l2_req(input icache_block_addr_u act, input icache_block_addr_u exp);
        if (act.raw !== exp.raw) begin
            fail_value($sformatf("l2_req_addr %h (tag %h set %h), expected %h",
                                 act.raw, act.fields.tag, act.fields.index, exp.raw));
        end
    endtask

    task automatic check_flag(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            fail_value($sformatf("%s is %b, expected %b", what, act, exp));
        end
    endtask

    // --------------------
    // stimulus file

    task automatic load_stimulus();
        int                         fd;
        int                         code;
        int                         want;
        logic [7:0]                 kind;
        logic [8*200-1:0]           line;
        logic [`ICACHE_BLOCK_W-1:0] f0, f1, f2, f3, f4, f5;

        fd = $fopen("testbench/icache_stim.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file testbench/icache_stim.txt");
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                if (kind == "#") begin
                    code = $fgets(line, fd);
                end else begin
                    f0 = '0;
                    f1 = '0;
                    f2 = '0;
                    f3 = '0;
                    f4 = '0;
                    f5 = '0;
                    want = (kind == "L") ? 6 : (kind == "M") ? 3 : (kind == "F") ? 4 : -1;
                    if (want < 0 || cmd_count == MAX_CMDS) begin
                        abort_run($sformatf("bad or excess stimulus command '%c'", kind));
                    end
                    code = $fscanf(fd, "%h", f0);
                    code += $fscanf(fd, "%h", f1);
                    code += $fscanf(fd, "%h", f2);
                    if (want > 3) begin
                        code += $fscanf(fd, "%h", f3);
                    end
                    if (want > 4) begin
                        code += $fscanf(fd, "%h", f4);
                        code += $fscanf(fd, "%h", f5);
                    end
                    if (code != want) begin
                        abort_run($sformatf("stimulus line %0d is missing fields", cmd_count));
                    end
                    cmds[cmd_count]      = kind;
                    fields[cmd_count][0] = f0;
                    fields[cmd_count][1] = f1;
                    fields[cmd_count][2] = f2;
                    fields[cmd_count][3] = f3;
                    fields[cmd_count][4] = f4;
                    fields[cmd_count][5] = f5;
                    cmd_count++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic expected_chunk(
        input  icache_block_addr_u           addr,
        input  logic [`ICACHE_BLKOFF_W-1:0]  half,
        output logic [`ICACHE_FETCH_W-1:0]   chunk
    );
        logic found;

        found = 1'b0;
        chunk = 'x;
        for (int i = 0; i < blk_count; i++) begin
            if (blk_addr[i] == addr.raw) begin
                found = 1'b1;
                chunk = blk_data[i][half*`ICACHE_FETCH_W +: `ICACHE_FETCH_W];
            end
        end
        if (!found) begin
            abort_run($sformatf("no block data known for address %h", addr.raw));
        end
    endtask

    // --------------------
    // core and L2 models

    task automatic run_lookup(
        input logic [`ICACHE_INDEX_W-1:0]                  index,
        input logic [`ICACHE_BLKOFF_W-1:0]                 half,
        input logic [`ICACHE_ASSOC-1:0]                    valid_exp,
        input logic [`ICACHE_ASSOC-1:0][`ICACHE_TAG_W-1:0] tag_exp,
        input logic [`ICACHE_TAG_W-1:0]                    fetch_tag
    );
        logic                       hit;
        logic [`ICACHE_WAY_W-1:0]   way;
        icache_block_addr_u         addr;
        logic [`ICACHE_FETCH_W-1:0] chunk;

        // core sees a hit where a valid way holds the fetch tag
        hit = 1'b0;
        way = '0;
        for (int w = 0; w < `ICACHE_ASSOC; w++) begin
            if (valid_exp[w] && tag_exp[w] == fetch_tag) begin
                hit = 1'b1;
                way = `ICACHE_WAY_W'(w);
            end
        end
        addr.fields.tag   = fetch_tag;
        addr.fields.index = index;

        @(posedge CLK);
        core_req_valid  <= 1'b1;
        core_req_index  <= index;
        core_req_blkoff <= half;
        @(posedge CLK);
        core_req_valid      <= 1'b0;
        core_resp_hit_valid <= hit;
        core_resp_hit_way   <= way;
        @(negedge CLK);
        check_resp(core_resp_valid_by_way, core_resp_tag_by_way, valid_exp, tag_exp, '1,
                   $sformatf("lookup set %h half %0d", index, half));
        if (hit) begin
            expected_chunk(addr, half, chunk);
            check_instr(core_resp_instr_by_way[way], chunk,
                        $sformatf("hit set %h way %0d", index, way));
        end
        check_flag(l2_req_valid, 1'b0, "l2_req_valid with no miss outstanding");
        @(posedge CLK);
        core_resp_hit_valid <= 1'b0;
    endtask

    task automatic run_miss(
        input logic [`ICACHE_INDEX_W-1:0] index,
        input logic [`ICACHE_TAG_W-1:0]   tag,
        input int                         hold
    );
        icache_block_addr_u exp_addr;

        exp_addr.fields.tag   = tag;
        exp_addr.fields.index = index;

        @(posedge CLK);
        core_req_valid  <= 1'b1;
        core_req_index  <= index;
        core_req_blkoff <= '0;
        @(posedge CLK);
        core_req_valid       <= 1'b0;
        core_resp_miss_valid <= 1'b1;
        core_resp_miss_tag   <= tag;
        @(posedge CLK);
        core_resp_miss_valid <= 1'b0;

        // request must stay put while L2 holds ready low
        for (int i = 0; i < hold; i++) begin
            @(negedge CLK);
            check_flag(l2_req_valid, 1'b1, "l2_req_valid under back-pressure");
            check_l2_req(l2_req_addr, exp_addr);
            @(posedge CLK);
        end
        l2_req_ready <= 1'b1;
        @(negedge CLK);
        check_flag(l2_req_valid, 1'b1, "l2_req_valid before acceptance");
        check_l2_req(l2_req_addr, exp_addr);
        @(posedge CLK);
        l2_req_ready <= 1'b0;
        @(negedge CLK);
        check_flag(l2_req_valid, 1'b0, "l2_req_valid after acceptance");
        pending_addr = exp_addr;
        miss_pending = 1'b1;
    endtask

    task automatic run_fill(
        input logic [`ICACHE_WAY_W-1:0]        way,
        input logic                            has_stray,
        input logic [`ICACHE_BLOCK_ADDR_W-1:0] stray_addr,
        input logic [`ICACHE_BLOCK_W-1:0]      data
    );
        logic [`ICACHE_ASSOC-1:0]                    care;
        logic [`ICACHE_ASSOC-1:0][`ICACHE_TAG_W-1:0] tag_exp;

        if (!miss_pending) begin
            abort_run("fill line found with no accepted miss request");
        end
        care           = '0;
        care[way]      = 1'b1;
        tag_exp        = '0;
        tag_exp[way]   = pending_addr.fields.tag;

        repeat (3) @(posedge CLK);
        // inverted data at a wrong address shows up later if it is taken
        if (has_stray) begin
            l2_resp_valid <= 1'b1;
            l2_resp_addr  <= stray_addr;
            l2_resp_data  <= ~data;
            @(posedge CLK);
            l2_resp_valid <= 1'b0;
            repeat (4) @(posedge CLK);
        end
        l2_resp_valid <= 1'b1;
        l2_resp_addr  <= pending_addr.raw;
        l2_resp_data  <= data;
        @(posedge CLK);
        l2_resp_valid <= 1'b0;
        repeat (2) @(posedge CLK);

        // earliest lookups that see the tag valid bit
        core_req_valid  <= 1'b1;
        core_req_index  <= pending_addr.fields.index;
        core_req_blkoff <= 1'b0;
        @(posedge CLK);
        core_req_blkoff <= 1'b1;
        @(negedge CLK);
        check_resp(core_resp_valid_by_way, core_resp_tag_by_way, care, tag_exp, care,
                   "fill half 0");
        check_instr(core_resp_instr_by_way[way], data[0 +: `ICACHE_FETCH_W], "fill half 0");
        @(posedge CLK);
        core_req_valid <= 1'b0;
        @(negedge CLK);
        check_resp(core_resp_valid_by_way, core_resp_tag_by_way, care, tag_exp, care,
                   "fill half 1");
        check_instr(core_resp_instr_by_way[way], data[`ICACHE_FETCH_W +: `ICACHE_FETCH_W],
                    "fill half 1");

        blk_addr[blk_count] = pending_addr.raw;
        blk_data[blk_count] = data;
        blk_count++;
        miss_pending = 1'b0;
    endtask

    // --------------------
    // main sequence

    initial begin : stimulus
        nRST                 = 1'b0;
        core_req_valid       = 1'b0;
        core_req_index       = '0;
        core_req_blkoff      = '0;
        core_resp_hit_valid  = 1'b0;
        core_resp_hit_way    = '0;
        core_resp_miss_valid = 1'b0;
        core_resp_miss_tag   = '0;
        l2_req_ready         = 1'b0;
        l2_resp_valid        = 1'b0;
        l2_resp_addr         = '0;
        l2_resp_data         = '0;

        load_stimulus();
        if (cmd_count == 0) begin
            abort_run("the stimulus file holds no commands");
        end
        stim_loaded = 1'b1;
        repeat (8) @(posedge CLK);
        nRST <= 1'b1;
        @(posedge CLK);

        for (int n = 0; n < cmd_count; n++) begin
            case (cmds[n])
                "L": run_lookup(fields[n][0][`ICACHE_INDEX_W-1:0],
                                fields[n][1][`ICACHE_BLKOFF_W-1:0],
                                fields[n][2][`ICACHE_ASSOC-1:0],
                                {fields[n][4][`ICACHE_TAG_W-1:0],
                                 fields[n][3][`ICACHE_TAG_W-1:0]},
                                fields[n][5][`ICACHE_TAG_W-1:0]);
                "M": run_miss(fields[n][0][`ICACHE_INDEX_W-1:0],
                              fields[n][1][`ICACHE_TAG_W-1:0],
                              int'(fields[n][2][15:0]));
                default: run_fill(fields[n][0][`ICACHE_WAY_W-1:0],
                                  fields[n][1][0],
                                  fields[n][2][`ICACHE_BLOCK_ADDR_W-1:0],
                                  fields[n][3]);
            endcase
        end
        repeat (2) @(posedge CLK);

        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
